// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = decode_issue_tb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim.f
src/decode_pkg.sv
src/issue_if.sv
src/inst_decoder.sv
src/reg_file.sv
src/scoreboard.sv
src/seq_counter.sv
src/issue_ctrl.sv
src/issue_slot.sv
src/decode_issue.sv
verif/decode_issue_tb.sv

// File: src/decode_issue.sv
/*
  Decode and issue stage top level
  Decoder, register file, scoreboard, tag counter, control, two issue slots
*/
`timescale 1ns/1ns

module decode_issue import decode_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  // Fetch side
  input  logic     fetch_val,
  output logic     fetch_rdy,
  input  addr_t    fetch_addr,
  input  inst_t    fetch_inst,
  // Writeback and completion
  input  logic     wb_en,
  input  reg_idx_t wb_rd,
  input  data_t    wb_data,
  input  logic     retire,
  input  logic     br_resolve,
  // Pipe 0, ALU memory branch
  output logic     p0_val,
  input  logic     p0_rdy,
  output addr_t    p0_pc,
  output data_t    p0_op1,
  output data_t    p0_op2,
  output uop_e     p0_uop,
  output reg_idx_t p0_rd,
  output seq_t     p0_seq,
  // Pipe 1, multiply
  output logic     p1_val,
  input  logic     p1_rdy,
  output addr_t    p1_pc,
  output data_t    p1_op1,
  output data_t    p1_op2,
  output uop_e     p1_uop,
  output reg_idx_t p1_rd,
  output seq_t     p1_seq
);

  uop_e       uop;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  data_t      imm;
  data_t      rd1;
  data_t      rd2;
  data_t      op2;
  seq_t       seq;
  logic       uses_rs2;
  logic       writes_rd;
  logic       is_branch;
  logic       pipe_sel;
  logic       hazard;
  logic       full;
  logic       issue;
  logic [1:0] slot_free;
  logic [1:0] load;

  issue_if in_if [2] ();
  issue_if out_if [2] ();

  // --------------------
  // Decode and operands
  // --------------------
  inst_decoder u_dec (
    .inst (fetch_inst), .uop (uop), .rs1 (rs1), .rs2 (rs2), .rd (rd), .imm (imm),
    .uses_rs2 (uses_rs2), .writes_rd (writes_rd), .is_branch (is_branch),
    .pipe_sel (pipe_sel)
  );

  reg_file u_rf (
    .clk (clk), .rs1 (rs1), .rs2 (rs2), .wb_en (wb_en), .wb_rd (wb_rd),
    .wb_data (wb_data), .rd1 (rd1), .rd2 (rd2)
  );

  // Immediate forms (addi, lw, jal) carry imm as op2
  assign op2 = uses_rs2 ? rd2 : imm;

  scoreboard u_sb (
    .clk (clk), .rst (rst), .rs1 (rs1), .rs2 (rs2), .uses_rs2 (uses_rs2),
    .set_en (issue && writes_rd), .set_rd (rd), .clr_en (wb_en), .clr_rd (wb_rd),
    .hazard (hazard)
  );

  seq_counter u_seq (
    .clk (clk), .rst (rst), .issue (issue), .retire (retire), .seq (seq), .full (full)
  );

  issue_ctrl u_ctrl (
    .clk (clk), .rst (rst), .fetch_val (fetch_val), .is_branch (is_branch),
    .hazard (hazard), .full (full), .slot_free (slot_free), .pipe_sel (pipe_sel),
    .br_resolve (br_resolve), .fetch_rdy (fetch_rdy), .issue (issue)
  );

  // --------------------
  // Issue slots
  // --------------------
  for (genvar g = 0; g < 2; g++) begin : g_pipe
    // Same message offered to both, only the selected pipe loads
    assign in_if[g].val = fetch_val && (pipe_sel == 1'(g));
    assign in_if[g].pc  = fetch_addr;
    assign in_if[g].op1 = rd1;
    assign in_if[g].op2 = op2;
    assign in_if[g].uop = uop;
    assign in_if[g].rd  = rd;
    assign in_if[g].seq = seq;
    assign load[g]      = issue && (pipe_sel == 1'(g));

    issue_slot u_slot (
      .clk (clk), .rst (rst), .load (load[g]),
      .in_msg (in_if[g]), .out_msg (out_if[g]), .free (slot_free[g])
    );
  end

  // Pipe 0 ports
  assign out_if[0].rdy = p0_rdy;
  assign p0_val = out_if[0].val;
  assign p0_pc  = out_if[0].pc;
  assign p0_op1 = out_if[0].op1;
  assign p0_op2 = out_if[0].op2;
  assign p0_uop = out_if[0].uop;
  assign p0_rd  = out_if[0].rd;
  assign p0_seq = out_if[0].seq;

  // Pipe 1 ports
  assign out_if[1].rdy = p1_rdy;
  assign p1_val = out_if[1].val;
  assign p1_pc  = out_if[1].pc;
  assign p1_op1 = out_if[1].op1;
  assign p1_op2 = out_if[1].op2;
  assign p1_uop = out_if[1].uop;
  assign p1_rd  = out_if[1].rd;
  assign p1_seq = out_if[1].seq;

endmodule

// File: src/decode_pkg.sv
/*
  Shared types and constants for the decode and issue stage
  Width typedefs, micro-op enum, pipe select, opcode and funct fields
*/
package decode_pkg;

  // --------------------
  // Widths
  // --------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [31:0] data_t;
  typedef logic [4:0]  reg_idx_t;

  // Issue tag, wraps modulo 16
  typedef logic [3:0]  seq_t;

  // --------------------
  // Micro-ops
  // --------------------
  typedef enum logic [2:0] {
    UOP_ADD = 3'd0,
    UOP_MUL = 3'd1,
    UOP_LW  = 3'd2,
    UOP_SW  = 3'd3,
    UOP_BNE = 3'd4,
    UOP_JAL = 3'd5,
    UOP_NOP = 3'd6
  } uop_e;

  // Pipe 0 takes ALU, memory and branch; pipe 1 multiply
  localparam logic PIPE_ALU = 1'b0;
  localparam logic PIPE_MUL = 1'b1;

  // Most issued but unretired instructions
  localparam int MAX_OUTSTANDING = 8;

  // --------------------
  // Encodings
  // --------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // add and mul share funct3, funct7 tells them apart
  localparam logic [2:0] FUNCT3_ADD = 3'b000;
  localparam logic [2:0] FUNCT3_LW  = 3'b010;
  localparam logic [2:0] FUNCT3_SW  = 3'b010;
  localparam logic [2:0] FUNCT3_BNE = 3'b001;
  localparam logic [6:0] FUNCT7_ADD = 7'b0000000;
  localparam logic [6:0] FUNCT7_MUL = 7'b0000001;

endpackage

// File: src/inst_decoder.sv
/*
  Instruction decoder for the TinyRV1 subset
  Micro-op, register fields, sign-extended immediate, pipe choice
*/
`timescale 1ns/1ns

module inst_decoder import decode_pkg::*; (
  input  inst_t    inst,
  output uop_e     uop,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output data_t    imm,
  output logic     uses_rs2,
  output logic     writes_rd,
  output logic     is_branch,
  output logic     pipe_sel
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       uses_rs1;
  logic       has_dest;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  always_comb begin
    // Unknown encodings fall through as a no-op on pipe 0
    uop      = UOP_NOP;
    imm      = '0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    has_dest = 1'b0;
    case (opcode)
      OPC_OP: begin
        if (funct3 == FUNCT3_ADD && funct7 == FUNCT7_ADD) begin
          uop = UOP_ADD;
        end else if (funct3 == FUNCT3_ADD && funct7 == FUNCT7_MUL) begin
          uop = UOP_MUL;
        end
        uses_rs1 = (uop != UOP_NOP);
        uses_rs2 = (uop != UOP_NOP);
        has_dest = (uop != UOP_NOP);
      end
      OPC_OP_IMM: begin
        if (funct3 == FUNCT3_ADD) begin
          // addi reuses the add micro-op with an I immediate
          uop      = UOP_ADD;
          imm      = {{20{inst[31]}}, inst[31:20]};
          uses_rs1 = 1'b1;
          has_dest = 1'b1;
        end
      end
      OPC_LOAD: begin
        if (funct3 == FUNCT3_LW) begin
          uop      = UOP_LW;
          imm      = {{20{inst[31]}}, inst[31:20]};
          uses_rs1 = 1'b1;
          has_dest = 1'b1;
        end
      end
      OPC_STORE: begin
        if (funct3 == FUNCT3_SW) begin
          // S immediate split across two fields
          uop      = UOP_SW;
          imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
          uses_rs1 = 1'b1;
          uses_rs2 = 1'b1;
        end
      end
      OPC_BRANCH: begin
        if (funct3 == FUNCT3_BNE) begin
          uop      = UOP_BNE;
          imm      = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
          uses_rs1 = 1'b1;
          uses_rs2 = 1'b1;
        end
      end
      OPC_JAL: begin
        uop      = UOP_JAL;
        imm      = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        has_dest = 1'b1;
      end
      default: begin
        uop = UOP_NOP;
      end
    endcase
  end

  // Unused sources read x0, which is never pending
  assign rs1       = uses_rs1 ? inst[19:15] : '0;
  assign rs2       = uses_rs2 ? inst[24:20] : '0;
  assign writes_rd = has_dest && (inst[11:7] != '0);
  assign rd        = writes_rd ? inst[11:7] : '0;
  assign is_branch = (uop == UOP_BNE) || (uop == UOP_JAL);
  assign pipe_sel  = (uop == UOP_MUL) ? PIPE_MUL : PIPE_ALU;

endmodule

// File: src/issue_ctrl.sv
/*
  Issue control FSM
  Fetch acceptance, stall conditions, branch wait
*/
`timescale 1ns/1ns

module issue_ctrl import decode_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       fetch_val,
  input  logic       is_branch,
  input  logic       hazard,
  input  logic       full,
  input  logic [1:0] slot_free,
  input  logic       pipe_sel,
  input  logic       br_resolve,
  output logic       fetch_rdy,
  output logic       issue
);

  typedef enum logic {
    RUN     = 1'b0,
    BR_WAIT = 1'b1
  } state_e;

  state_e state;
  state_e state_next;

  // --------------------
  // Handshake
  // --------------------
  // Target slot must have room and operands must be ready
  assign fetch_rdy = (state == RUN) && slot_free[pipe_sel] && !hazard && !full;
  assign issue     = fetch_val && fetch_rdy;

  // --------------------
  // State
  // --------------------
  always_comb begin
    state_next = state;
    case (state)
      RUN: begin
        // Stop fetch until the branch outcome is known
        if (issue && is_branch) begin
          state_next = BR_WAIT;
        end
      end
      BR_WAIT: begin
        if (br_resolve) begin
          state_next = RUN;
        end
      end
      default: begin
        state_next = RUN;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RUN;
    end else begin
      state <= state_next;
    end
  end

  a_resolve_in_wait: assert property (@(posedge clk) disable iff (rst)
    br_resolve |-> (state == BR_WAIT))
    else $error("br_resolve with no branch in flight");

endmodule

// File: src/issue_if.sv
/*
  Issue message channel with val/rdy handshake
*/
`timescale 1ns/1ns

interface issue_if import decode_pkg::*; ();

  logic     val;
  logic     rdy;

  // Message payload
  addr_t    pc;
  data_t    op1;
  data_t    op2;
  uop_e     uop;
  reg_idx_t rd;
  seq_t     seq;

  // Producer holds val and payload until the transfer
  modport send (output val, pc, op1, op2, uop, rd, seq, input rdy);

  // Consumer only answers with rdy
  modport recv (input val, pc, op1, op2, uop, rd, seq, output rdy);

endinterface

// File: src/issue_slot.sv
/*
  One-entry issue register for a single pipe
  Holds the message while the pipe applies back-pressure
*/
`timescale 1ns/1ns

module issue_slot import decode_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic load,
  issue_if.recv in_msg,
  issue_if.send out_msg,
  output logic free
);

  logic occupied;

  // Room if empty or the held message leaves this cycle
  assign free       = !occupied || out_msg.rdy;
  assign in_msg.rdy = free;

  always_ff @(posedge clk) begin
    if (rst) begin
      occupied <= 1'b0;
    end else if (load) begin
      occupied <= 1'b1;
    end else if (out_msg.rdy) begin
      occupied <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (load) begin
      out_msg.pc  <= in_msg.pc;
      out_msg.op1 <= in_msg.op1;
      out_msg.op2 <= in_msg.op2;
      out_msg.uop <= in_msg.uop;
      out_msg.rd  <= in_msg.rd;
      out_msg.seq <= in_msg.seq;
    end
  end

  assign out_msg.val = occupied;

  // Capture only an offered message into a slot with room
  a_load_legal: assert property (@(posedge clk) disable iff (rst)
    load |-> (in_msg.val && in_msg.rdy))
    else $error("slot loaded without a valid handshake");

  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    (out_msg.val && !out_msg.rdy) |=> (out_msg.val && $stable(out_msg.seq)))
    else $error("issue message changed under back-pressure");

endmodule

// File: src/reg_file.sv
/*
  Integer register file, 2 read ports and 1 write port
  x0 reads zero, writes bypass to same-cycle reads
*/
`timescale 1ns/1ns

module reg_file import decode_pkg::*; (
  input  logic     clk,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  logic     wb_en,
  input  reg_idx_t wb_rd,
  input  data_t    wb_data,
  output data_t    rd1,
  output data_t    rd2
);

  // x0 has no storage
  data_t regs [1:31];

  always_ff @(posedge clk) begin
    if (wb_en && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Read with writeback forwarding
  assign rd1 = (rs1 == '0)                  ? '0      :
               (wb_en && wb_rd == rs1)      ? wb_data : regs[rs1];
  assign rd2 = (rs2 == '0)                  ? '0      :
               (wb_en && wb_rd == rs2)      ? wb_data : regs[rs2];

  a_x0_zero: assert property (@(posedge clk)
    ((rs1 == '0) |-> (rd1 == '0)) and ((rs2 == '0) |-> (rd2 == '0)))
    else $error("x0 read returned nonzero");

endmodule

// File: src/scoreboard.sv
/*
  Pending-write scoreboard, one bit per register
  Flags a source hazard against in-flight writers
*/
`timescale 1ns/1ns

module scoreboard import decode_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  logic     uses_rs2,
  input  logic     set_en,
  input  reg_idx_t set_rd,
  input  logic     clr_en,
  input  reg_idx_t clr_rd,
  output logic     hazard
);

  logic [31:0] pending;
  logic        clr_rs1;
  logic        clr_rs2;

  // Clear wins when set and clear hit the same register
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (set_en && set_rd != '0) begin
        pending[set_rd] <= 1'b1;
      end
      if (clr_en) begin
        pending[clr_rd] <= 1'b0;
      end
    end
  end

  // Writeback this cycle is already bypassed by the register file
  assign clr_rs1 = clr_en && (clr_rd == rs1);
  assign clr_rs2 = clr_en && (clr_rd == rs2);
  assign hazard  = (pending[rs1] && !clr_rs1) ||
                   (uses_rs2 && pending[rs2] && !clr_rs2);

  a_clr_pending: assert property (@(posedge clk) disable iff (rst)
    clr_en |-> pending[clr_rd])
    else $error("writeback to r%0d with no pending write", clr_rd);

endmodule

// File: src/seq_counter.sv
/*
  Issue sequence tag and outstanding-instruction count
*/
`timescale 1ns/1ns

module seq_counter import decode_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic issue,
  input  logic retire,
  output seq_t seq,
  output logic full
);

  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (rst) begin
      seq   <= '0;
      count <= '0;
    end else begin
      // Tag for the next issue, wraps freely
      if (issue) begin
        seq <= seq + 1'b1;
      end
      // Issue and retire together cancel out
      case ({issue, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign full = (count == CNT_W'(MAX_OUTSTANDING));

  // --------------------
  // Checks
  // --------------------
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    retire |-> (count != '0))
    else $error("retire with nothing outstanding");

  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    count <= CNT_W'(MAX_OUTSTANDING))
    else $error("outstanding count %0d past limit", count);

endmodule

// File: verif/decode_issue_tb.sv
/*
  Testbench for the decode and issue stage
  Instruction table with reference model, fetch driver, pipe sinks, responder
*/
`timescale 1ns/1ns

module decode_issue_tb import decode_pkg::*; ();

  localparam int N_MAIN  = 16;
  localparam int N_FULL  = 10;
  localparam int N_TOTAL = N_MAIN + N_FULL;
  // Two passes over the main program plus the outstanding-limit run
  localparam int TIMEOUT_CYCLES = 40 * (2 * N_MAIN + N_FULL);

  typedef struct packed {
    addr_t    pc;
    inst_t    inst;
    logic     pipe;
    uop_e     uop;
    data_t    op1;
    data_t    op2;
    reg_idx_t rd;
    reg_idx_t src1;
    reg_idx_t src2;
    logic     wb;
    data_t    wb_data;
  } entry_t;

  // DUT inputs
  logic     clk = 1'b0;
  logic     rst = 1'b1;
  logic     fetch_val = 1'b0;
  addr_t    fetch_addr = '0;
  inst_t    fetch_inst = '0;
  logic     wb_en = 1'b0;
  reg_idx_t wb_rd = '0;
  data_t    wb_data = '0;
  logic     retire = 1'b0;
  logic     br_resolve = 1'b0;
  logic     p0_rdy = 1'b0;
  logic     p1_rdy = 1'b0;
  // DUT outputs
  logic     fetch_rdy;
  logic     p0_val;
  logic     p1_val;
  addr_t    p0_pc;
  addr_t    p1_pc;
  data_t    p0_op1;
  data_t    p0_op2;
  data_t    p1_op1;
  data_t    p1_op2;
  uop_e     p0_uop;
  uop_e     p1_uop;
  reg_idx_t p0_rd;
  reg_idx_t p1_rd;
  seq_t     p0_seq;
  seq_t     p1_seq;

  // Table and reference register state
  entry_t tbl [N_TOTAL];
  data_t  model [32];
  int     n_entries = 0;
  addr_t  next_pc = 32'h0000_1000;

  // Run control set by the main process
  int   cur_idx = 0;
  logic random_rdy = 1'b0;
  logic hold_retire = 1'b0;
  int   run_errors = 0;
  int   run_checks = 0;

  // Monitor state
  int          mon_errors = 0;
  int          mon_checks = 0;
  int          accepted = 0;
  int          retired = 0;
  seq_t        next_tag = '0;
  logic        br_wait = 1'b0;
  logic [31:0] pend = '0;
  int          exp_idx0 [$];
  int          exp_idx1 [$];
  seq_t        exp_tag0 [$];
  seq_t        exp_tag1 [$];
  int          done_idx [$];
  int          done_due [$];

  int          done_ptr = 0;
  int          cycle = 0;
  logic [31:0] rng = 32'd90492;

  decode_issue dut (.*);

  always #50 clk = ~clk;

  // --------------------
  // Encoders and model
  // --------------------
  function automatic inst_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input reg_idx_t rd);
    return {f7, rs2, rs1, FUNCT3_ADD, rd, OPC_OP};
  endfunction

  function automatic inst_t enc_i(input data_t imm, input reg_idx_t rs1, input logic [2:0] f3,
                                  input reg_idx_t rd, input logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic inst_t enc_s(input data_t imm, input reg_idx_t rs2, input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, FUNCT3_SW, imm[4:0], OPC_STORE};
  endfunction

  function automatic inst_t enc_b(input data_t imm, input reg_idx_t rs2, input reg_idx_t rs1);
    return {imm[12], imm[10:5], rs2, rs1, FUNCT3_BNE, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic inst_t enc_j(input data_t imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Expected operands come from the model registers in program order
  task automatic add_entry(input inst_t inst, input logic pipe, input uop_e uop,
                           input reg_idx_t rd, input reg_idx_t src1, input reg_idx_t src2,
                           input logic use_imm, input data_t imm);
    entry_t e;
    e.pc   = next_pc;
    e.inst = inst;
    e.pipe = pipe;
    e.uop  = uop;
    e.src1 = src1;
    e.src2 = src2;
    e.op1  = model[src1];
    e.op2  = use_imm ? imm : model[src2];
    case (uop)
      UOP_ADD: e.wb_data = e.op1 + e.op2;
      UOP_MUL: e.wb_data = e.op1 * e.op2;
      // Made-up load data
      UOP_LW:  e.wb_data = 32'h1000_0000 ^ (e.op1 + e.op2);
      UOP_JAL: e.wb_data = e.pc + 32'd4;
      default: e.wb_data = '0;
    endcase
    e.wb = (rd != '0) && (uop inside {UOP_ADD, UOP_MUL, UOP_LW, UOP_JAL});
    e.rd = e.wb ? rd : '0;
    if (e.wb) begin
      model[rd] = e.wb_data;
    end
    tbl[n_entries] = e;
    n_entries++;
    next_pc += 32'd4;
  endtask

  task automatic build_table();
    for (int r = 0; r < 32; r++) begin
      model[r] = '0;
    end
    // Main program with RAW chains through x1..x10 and distinct destinations
    add_entry(enc_i(5, 0, FUNCT3_ADD, 1, OPC_OP_IMM), PIPE_ALU, UOP_ADD, 1, 0, 0, 1, 5);
    add_entry(enc_i(-3, 0, FUNCT3_ADD, 2, OPC_OP_IMM), PIPE_ALU, UOP_ADD, 2, 0, 0, 1, -3);
    add_entry(enc_r(FUNCT7_ADD, 2, 1, 3), PIPE_ALU, UOP_ADD, 3, 1, 2, 0, 0);
    add_entry(enc_r(FUNCT7_MUL, 3, 1, 4), PIPE_MUL, UOP_MUL, 4, 1, 3, 0, 0);
    add_entry(enc_i(8, 1, FUNCT3_LW, 5, OPC_LOAD), PIPE_ALU, UOP_LW, 5, 1, 0, 1, 8);
    add_entry(enc_s(-4, 4, 2), PIPE_ALU, UOP_SW, 0, 2, 4, 0, 0);
    add_entry(enc_r(FUNCT7_MUL, 5, 4, 6), PIPE_MUL, UOP_MUL, 6, 4, 5, 0, 0);
    add_entry(enc_b(16, 3, 1), PIPE_ALU, UOP_BNE, 0, 1, 3, 0, 0);
    add_entry(enc_i(100, 6, FUNCT3_ADD, 7, OPC_OP_IMM), PIPE_ALU, UOP_ADD, 7, 6, 0, 1, 100);
    add_entry(enc_j(2048, 8), PIPE_ALU, UOP_JAL, 8, 0, 0, 1, 2048);
    add_entry(enc_r(FUNCT7_ADD, 1, 1, 0), PIPE_ALU, UOP_ADD, 0, 1, 1, 0, 0);
    add_entry(enc_r(FUNCT7_MUL, 2, 7, 9), PIPE_MUL, UOP_MUL, 9, 7, 2, 0, 0);
    // Unsupported opcode issues as a no-op on pipe 0
    add_entry(32'hFFFF_FFFF, PIPE_ALU, UOP_NOP, 0, 0, 0, 1, 0);
    add_entry(enc_s(12, 9, 0), PIPE_ALU, UOP_SW, 0, 0, 9, 0, 0);
    add_entry(enc_r(FUNCT7_ADD, 8, 9, 10), PIPE_ALU, UOP_ADD, 10, 9, 8, 0, 0);
    add_entry(enc_b(-8, 0, 10), PIPE_ALU, UOP_BNE, 0, 10, 0, 0, 0);
    // Independent writers for the outstanding limit
    for (int k = 0; k < N_FULL; k++) begin
      add_entry(enc_i(k + 1, 0, FUNCT3_ADD, 5'(20 + k), OPC_OP_IMM), PIPE_ALU, UOP_ADD,
                5'(20 + k), 0, 0, 1, k + 1);
    end
  endtask

  // --------------------
  // Checks
  // --------------------
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    mon_checks++;
    assert (got === exp) else begin
      $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      mon_errors++;
    end
  endtask

  task automatic check_msg(input int pipe, input addr_t pc, input data_t op1, input data_t op2,
                           input uop_e uop, input reg_idx_t rd, input seq_t tag);
    int    n;
    int    idx;
    seq_t  exp_tag;
    string p;
    p = $sformatf("p%0d_", pipe);
    n = (pipe == 0) ? exp_idx0.size() : exp_idx1.size();
    mon_checks++;
    assert (n != 0) else begin
      $display("ERROR: pipe %0d issued a message at %0t that was never fetched", pipe, $time);
      mon_errors++;
    end
    if (n != 0) begin
      if (pipe == 0) begin
        idx     = exp_idx0.pop_front();
        exp_tag = exp_tag0.pop_front();
      end else begin
        idx     = exp_idx1.pop_front();
        exp_tag = exp_tag1.pop_front();
      end
      check_val({p, "pc"}, pc, tbl[idx].pc);
      check_val({p, "op1"}, op1, tbl[idx].op1);
      check_val({p, "op2"}, op2, tbl[idx].op2);
      check_val({p, "uop"}, 32'(uop), 32'(tbl[idx].uop));
      check_val({p, "rd"}, 32'(rd), 32'(tbl[idx].rd));
      check_val({p, "seq"}, 32'(tag), 32'(exp_tag));
      // Execute latency of 2 to 4 cycles
      done_idx.push_back(idx);
      done_due.push_back(cycle + 2 + idx % 3);
    end
  endtask

  // Sampled mid-cycle when all inputs have settled
  always @(negedge clk) begin
    if (!rst) begin
      // Same-cycle writeback counts as available through the bypass
      if (wb_en) begin
        pend[wb_rd] = 1'b0;
      end
      if (retire) begin
        retired++;
      end
      if (fetch_val && fetch_rdy) begin
        mon_checks++;
        assert (!br_wait) else begin
          $display("ERROR: fetch accepted at %0t before the branch resolved", $time);
          mon_errors++;
        end
        assert (!pend[tbl[cur_idx].src1] && !pend[tbl[cur_idx].src2]) else begin
          $display("ERROR: entry %0d issued at %0t with a source still pending", cur_idx, $time);
          mon_errors++;
        end
        if (tbl[cur_idx].pipe == PIPE_ALU) begin
          exp_idx0.push_back(cur_idx);
          exp_tag0.push_back(next_tag);
        end else begin
          exp_idx1.push_back(cur_idx);
          exp_tag1.push_back(next_tag);
        end
        next_tag = next_tag + 1'b1;
        accepted++;
        if (tbl[cur_idx].wb) begin
          pend[tbl[cur_idx].rd] = 1'b1;
        end
        if (tbl[cur_idx].uop inside {UOP_BNE, UOP_JAL}) begin
          br_wait = 1'b1;
        end
      end
      if (br_resolve) begin
        br_wait = 1'b0;
      end
      if (p0_val && p0_rdy) begin
        check_msg(0, p0_pc, p0_op1, p0_op2, p0_uop, p0_rd, p0_seq);
      end
      if (p1_val && p1_rdy) begin
        check_msg(1, p1_pc, p1_op1, p1_op2, p1_uop, p1_rd, p1_seq);
      end
    end
  end

  // --------------------
  // Pipe sinks and responder
  // --------------------
  always @(posedge clk) begin
    rng = xorshift(rng);
    p0_rdy <= !random_rdy || rng[4];
    p1_rdy <= !random_rdy || rng[13];
  end

  // Completes one transferred message per cycle once its latency is up
  always @(posedge clk) begin
    wb_en      <= 1'b0;
    retire     <= 1'b0;
    br_resolve <= 1'b0;
    if (!rst && !hold_retire && done_ptr < done_idx.size()) begin
      if (cycle >= done_due[done_ptr]) begin
        if (tbl[done_idx[done_ptr]].wb) begin
          wb_en   <= 1'b1;
          wb_rd   <= tbl[done_idx[done_ptr]].rd;
          wb_data <= tbl[done_idx[done_ptr]].wb_data;
        end
        retire     <= 1'b1;
        br_resolve <= tbl[done_idx[done_ptr]].uop inside {UOP_BNE, UOP_JAL};
        done_ptr++;
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", cycle);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // --------------------
  // Fetch driver and tests
  // --------------------
  task automatic fetch_range(input int first, input int last);
    int target;
    @(posedge clk);
    for (int i = first; i < last; i++) begin
      cur_idx = i;
      fetch_val  <= 1'b1;
      fetch_addr <= tbl[i].pc;
      fetch_inst <= tbl[i].inst;
      target = accepted + 1;
      do @(posedge clk); while (accepted < target);
    end
    fetch_val <= 1'b0;
  endtask

  // Wait until every accepted instruction retires and settle to mid-cycle
  task automatic wait_drain();
    do @(posedge clk); while (retired != accepted);
    repeat (2) @(negedge clk);
  endtask

  function automatic int total_errors();
    return mon_errors + run_errors;
  endfunction

  task automatic report_test(input string name, input int errs_before);
    $display("[%0t] %s finished, %0d errors", $time, name, total_errors() - errs_before);
  endtask

  initial begin
    int errs;
    int base;
    build_table();
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    errs = total_errors();
    fetch_range(0, N_MAIN);
    wait_drain();
    report_test("table with pipes always ready", errs);

    errs = total_errors();
    random_rdy = 1'b1;
    fetch_range(0, N_MAIN);
    wait_drain();
    random_rdy = 1'b0;
    report_test("table under random back-pressure", errs);

    // Retire withheld so fetch must stop at the limit
    errs = total_errors();
    base = accepted;
    hold_retire = 1'b1;
    fork
      fetch_range(N_MAIN, N_TOTAL);
      begin
        wait (accepted >= base + MAX_OUTSTANDING);
        repeat (12) begin
          @(negedge clk);
          run_checks++;
          assert (!fetch_rdy) else begin
            $display("ERROR: fetch_rdy high at %0t with the outstanding limit reached", $time);
            run_errors++;
          end
        end
        @(posedge clk);
        run_checks++;
        assert (accepted == base + MAX_OUTSTANDING) else begin
          $display("ERROR: %0d issued with retire withheld", accepted - base);
          run_errors++;
        end
        @(negedge clk);
        hold_retire = 1'b0;
      end
    join
    wait_drain();
    report_test("outstanding limit with retire withheld", errs);

    $display("checks %0d, errors %0d", mon_checks + run_checks, total_errors());
    if (total_errors() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
